//--- vlog.f
+incdir+design
design/div_ctrl_pkg.sv
design/div_msg_pkg.sv
design/div_req_in.sv
design/div_iter_core.sv
design/div_resp_out.sv
design/div_unit.sv
sim/div_props.sv
sim/div_tb_clk.sv
sim/div_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the divider testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f vlog.f --top-module div_tb -Mdir obj_dir &&
  ./obj_dir/Vdiv_tb ||
  { echo "simulation did not complete cleanly"; exit 1; }

//--- sim/div_tb.sv
// divider testbench, directed table rows then random rows from a fixed seed
// requests and response acks run in parallel, so several divisions overlap

`timescale 1ns/1ps

`include "div_defines.svh"

module div_tb;

  import div_msg_pkg::*;

  logic          clk;
  logic          reset;
  logic          req_req;
  logic          req_ack;
  div_req_msg_t  req_msg;
  logic          resp_req;
  logic          resp_ack;
  div_resp_msg_t resp_msg;

  // stimulus rows, expected words and consumer stalls in request order
  string                   name_q[$];
  div_req_msg_t            req_q[$];
  logic [2*`DIV_WIDTH-1:0] exp_q[$];
  int                      stall_q[$];
  int                      stall_sum = 0;
  integer                  seed = 19341;
  int                      cycle_cnt = 0;
  int                      cycle_limit = 0;

  div_tb_clk u_clk (
    .clk   (clk),
    .reset (reset)
  );

  div_unit dut (
    .clk      (clk),
    .reset    (reset),
    .req_req  (req_req),
    .req_ack  (req_ack),
    .req_msg  (req_msg),
    .resp_req (resp_req),
    .resp_ack (resp_ack),
    .resp_msg (resp_msg)
  );

  bind div_unit div_props u_props (
    .clk      (clk),
    .reset    (reset),
    .req_req  (req_req),
    .req_ack  (req_ack),
    .req_msg  (req_msg),
    .op_req   (op_req),
    .op_ack   (op_ack),
    .op_msg   (op_msg),
    .raw_req  (raw_req),
    .raw_ack  (raw_ack),
    .raw_msg  (raw_msg),
    .resp_req (resp_req),
    .resp_ack (resp_ack),
    .resp_msg (resp_msg)
  );

  // -------------------------------------------------------------------------
  // reference model and checking
  // -------------------------------------------------------------------------

  // truncating division, remainder takes the dividend sign, x/0 is all ones
  function automatic logic [2*`DIV_WIDTH-1:0] ref_div(input logic fn,
      input logic [`DIV_WIDTH-1:0] a, input logic [`DIV_WIDTH-1:0] b);
    logic signed [`DIV_WIDTH-1:0] sa;
    logic signed [`DIV_WIDTH-1:0] sb;
    logic [`DIV_WIDTH-1:0]        q;
    logic [`DIV_WIDTH-1:0]        r;
    sa = a;
    sb = b;
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (!fn) begin
      q = a / b;
      r = a % b;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // overflow case wraps back to the most negative value
      q = a;
      r = '0;
    end else begin
      q = sa / sb;
      r = sa % sb;
    end
    return {r, q};
  endfunction

  task automatic check_value(input string name, input logic [2*`DIV_WIDTH-1:0] expected,
                             input logic [2*`DIV_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      $display("Test failures found");
      $fatal(1, "response mismatch");
    end
  endtask

  // -------------------------------------------------------------------------
  // stimulus table
  // -------------------------------------------------------------------------

  task automatic add_row(input string name, input logic fn, input logic [`DIV_WIDTH-1:0] a,
                         input logic [`DIV_WIDTH-1:0] b,
                         input logic [2*`DIV_WIDTH-1:0] expected, input int stall);
    name_q.push_back(name);
    req_q.push_back({fn, a, b});
    exp_q.push_back(expected);
    stall_q.push_back(stall);
    stall_sum = stall_sum + stall;
  endtask

  // expected word is {rem, quo}
  task automatic build_table();
    add_row("udiv_basic",      1'b0, 32'h0000_0064, 32'h0000_0007, {32'h2, 32'he}, 0);
    add_row("udiv_b_gt_a",     1'b0, 32'h0000_0005, 32'h0000_0009, {32'h5, 32'h0}, 0);
    add_row("udiv_ones_by_10", 1'b0, 32'hffff_ffff, 32'h0000_000a, {32'h5, 32'h1999_9999}, 0);
    add_row("udiv_ones_by_1",  1'b0, 32'hffff_ffff, 32'h0000_0001, {32'h0, 32'hffff_ffff}, 0);
    add_row("udiv_msb_by_3",   1'b0, 32'h8000_0000, 32'h0000_0003, {32'h2, 32'h2aaa_aaaa}, 0);
    add_row("udiv_neg_bits",   1'b0, 32'hffff_fff9, 32'h0000_0002, {32'h1, 32'h7fff_fffc}, 0);
    add_row("sdiv_pos_pos",    1'b1, 32'h0000_0007, 32'h0000_0002, {32'h1, 32'h3}, 0);
    add_row("sdiv_neg_pos",    1'b1, 32'hffff_fff9, 32'h0000_0002,
            {32'hffff_ffff, 32'hffff_fffd}, 0);
    add_row("sdiv_pos_neg",    1'b1, 32'h0000_0007, 32'hffff_fffe, {32'h1, 32'hffff_fffd}, 0);
    add_row("sdiv_neg_neg",    1'b1, 32'hffff_fff9, 32'hffff_fffe, {32'hffff_ffff, 32'h3}, 0);
    add_row("udiv_by_zero",    1'b0, 32'h0000_04d2, 32'h0000_0000, {32'h4d2, 32'hffff_ffff}, 0);
    add_row("sdiv_by_zero",    1'b1, 32'hffff_fffb, 32'h0000_0000,
            {32'hffff_fffb, 32'hffff_ffff}, 0);
    add_row("sdiv_min_by_m1",  1'b1, 32'h8000_0000, 32'hffff_ffff, {32'h0, 32'h8000_0000}, 0);
  endtask

  // divisor shifted right by a random amount so quotients are not mostly zero
  task automatic add_random_rows(input string name, input int count, input int max_stall);
    logic                  fn;
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;
    int                    stall;
    for (int i = 0; i < count; i++) begin
      fn    = 1'($random(seed));
      a     = $random(seed);
      b     = $random(seed);
      b     = b >> ($unsigned($random(seed)) % 32);
      stall = $unsigned($random(seed)) % (max_stall + 1);
      add_row($sformatf("%s_%0d", name, i), fn, a, b, ref_div(fn, a, b), stall);
    end
  endtask

  // -------------------------------------------------------------------------
  // handshake drivers
  // -------------------------------------------------------------------------

  // next request goes out as soon as the previous ack has fallen
  task automatic drive_requests();
    for (int i = 0; i < req_q.size(); i++) begin
      req_req <= 1'b1;
      req_msg <= req_q[i];
      do @(posedge clk); while (!req_ack);
      req_req <= 1'b0;
      do @(posedge clk); while (req_ack);
    end
  endtask

  // checks once at resp_req and again after a nonzero stall
  task automatic take_responses();
    string                   name;
    logic [2*`DIV_WIDTH-1:0] expected;
    int                      stall;
    while (exp_q.size() != 0) begin
      name     = name_q.pop_front();
      expected = exp_q.pop_front();
      stall    = stall_q.pop_front();
      do @(posedge clk); while (!resp_req);
      check_value(name, expected, resp_msg);
      if (stall != 0) begin
        repeat (stall) @(posedge clk);
        check_value({name, "_held"}, expected, resp_msg);
      end
      resp_ack <= 1'b1;
      do @(posedge clk); while (resp_req);
      resp_ack <= 1'b0;
    end
  endtask

  // -------------------------------------------------------------------------
  // run control
  // -------------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, not all responses arrived", cycle_cnt);
      $display("Test failures found");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    req_req  <= 1'b0;
    req_msg  <= '0;
    resp_ack <= 1'b0;
    build_table();
    add_random_rows("rand_stall", 12, 7);
    add_random_rows("rand_b2b", 24, 0);
    // 39 cycles per division on an idle pipe, plus consumer stalls and reset
    cycle_limit = req_q.size() * 39 + stall_sum + 100;
    @(posedge clk);
    while (reset) @(posedge clk);
    fork
      drive_requests();
      take_responses();
    join
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- sim/div_tb_clk.sv
// clock and reset for the divider testbench
// 4 ns period, reset high for the first 5 rising edges

`timescale 1ns/1ps

module div_tb_clk (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // reset releases on the fifth rising edge
  initial begin
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- sim/div_props.sv
// four-phase handshake checks on every link of the divider
// bound into div_unit, checks are off while reset is high

`timescale 1ns/1ps

module div_props (
  input logic                       clk,
  input logic                       reset,
  input logic                       req_req,
  input logic                       req_ack,
  input div_msg_pkg::div_req_msg_t  req_msg,
  input logic                       op_req,
  input logic                       op_ack,
  input div_msg_pkg::div_op_msg_t   op_msg,
  input logic                       raw_req,
  input logic                       raw_ack,
  input div_msg_pkg::div_raw_msg_t  raw_msg,
  input logic                       resp_req,
  input logic                       resp_ack,
  input div_msg_pkg::div_resp_msg_t resp_msg
);

  // -------------------------------------------------------------------------
  // req holds with a stable message until ack rises
  // -------------------------------------------------------------------------

  req_hold: assert property (@(posedge clk) disable iff (reset)
    req_req && !req_ack |=> req_req && $stable(req_msg))
    else $error("request link: req_req fell or req_msg moved before req_ack");

  op_hold: assert property (@(posedge clk) disable iff (reset)
    op_req && !op_ack |=> op_req && $stable(op_msg))
    else $error("operand link: op_req fell or op_msg moved before op_ack");

  raw_hold: assert property (@(posedge clk) disable iff (reset)
    raw_req && !raw_ack |=> raw_req && $stable(raw_msg))
    else $error("result link: raw_req fell or raw_msg moved before raw_ack");

  // response side, this is where back-pressure from the consumer lands
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_req && !resp_ack |=> resp_req && $stable(resp_msg))
    else $error("response link: resp_req fell or resp_msg moved before resp_ack");

  // -------------------------------------------------------------------------
  // ack only ever answers a pending req
  // -------------------------------------------------------------------------

  req_ack_cause: assert property (@(posedge clk) disable iff (reset)
    $rose(req_ack) |-> $past(req_req))
    else $error("req_ack rose without req_req");

  op_ack_cause: assert property (@(posedge clk) disable iff (reset)
    $rose(op_ack) |-> $past(op_req))
    else $error("op_ack rose without op_req");

  raw_ack_cause: assert property (@(posedge clk) disable iff (reset)
    $rose(raw_ack) |-> $past(raw_req))
    else $error("raw_ack rose without raw_req");

  resp_ack_cause: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_ack) |-> $past(resp_req))
    else $error("resp_ack rose without resp_req");

endmodule

//--- design/div_unit.sv
// 32-bit iterative divider, fn 0 unsigned and fn 1 signed
// up to three divisions in flight, results leave in request order

`timescale 1ns/1ps

module div_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req_req,
  output logic                       req_ack,
  input  div_msg_pkg::div_req_msg_t  req_msg,
  output logic                       resp_req,
  input  logic                       resp_ack,
  output div_msg_pkg::div_resp_msg_t resp_msg
);

  import div_msg_pkg::*;

  // input side to core
  logic         op_req;
  logic         op_ack;
  div_op_msg_t  op_msg;

  // core to output side
  logic         raw_req;
  logic         raw_ack;
  div_raw_msg_t raw_msg;

  // -----------------------------------------------------------------------
  // stages
  // -----------------------------------------------------------------------

  div_req_in u_req_in (
    .clk     (clk),
    .reset   (reset),
    .req_req (req_req),
    .req_ack (req_ack),
    .req_msg (req_msg),
    .op_req  (op_req),
    .op_ack  (op_ack),
    .op_msg  (op_msg)
  );

  div_iter_core u_core (
    .clk     (clk),
    .reset   (reset),
    .op_req  (op_req),
    .op_ack  (op_ack),
    .op_msg  (op_msg),
    .raw_req (raw_req),
    .raw_ack (raw_ack),
    .raw_msg (raw_msg)
  );

  div_resp_out u_resp_out (
    .clk      (clk),
    .reset    (reset),
    .raw_req  (raw_req),
    .raw_ack  (raw_ack),
    .raw_msg  (raw_msg),
    .resp_req (resp_req),
    .resp_ack (resp_ack),
    .resp_msg (resp_msg)
  );

endmodule

//--- design/div_resp_out.sv
// applies the result signs and sends the response word
// one result slot, the response holds until resp_ack under back-pressure

`timescale 1ns/1ps

module div_resp_out (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       raw_req,
  output logic                       raw_ack,
  input  div_msg_pkg::div_raw_msg_t  raw_msg,
  output logic                       resp_req,
  input  logic                       resp_ack,
  output div_msg_pkg::div_resp_msg_t resp_msg
);

  import div_msg_pkg::*;

  logic          held;
  logic          accept;
  div_resp_msg_t resp_next;

  // -----------------------------------------------------------------------
  // sign restore
  // -----------------------------------------------------------------------

  always_comb begin
    // two's complement negate where the input side asked for it
    resp_next.quo = raw_msg.neg_quo ? -raw_msg.quo : raw_msg.quo;
    resp_next.rem = raw_msg.neg_rem ? -raw_msg.rem : raw_msg.rem;
  end

  // -----------------------------------------------------------------------
  // handshakes
  // -----------------------------------------------------------------------

  // take a result only with an empty slot and raw_ack back low
  assign accept = raw_req & ~raw_ack & ~held;

  // response payload
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_msg <= resp_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      raw_ack  <= 1'b0;
      held     <= 1'b0;
      resp_req <= 1'b0;
    end else begin
      // raw side
      if (accept) begin
        raw_ack <= 1'b1;
      end else if (raw_ack && !raw_req) begin
        raw_ack <= 1'b0;
      end
      // slot stays full until the consumer acknowledges
      if (accept) begin
        held <= 1'b1;
      end else if (resp_req && resp_ack) begin
        held <= 1'b0;
      end
      // response side, no new req while the old ack is still high
      if (resp_req && resp_ack) begin
        resp_req <= 1'b0;
      end else if (held && !resp_req && !resp_ack) begin
        resp_req <= 1'b1;
      end
    end
  end

endmodule

//--- design/div_iter_core.sv
// restoring shift-subtract core, one quotient bit per cycle
// holds one division at a time and takes new operands only in IDLE

`timescale 1ns/1ps

`include "div_defines.svh"

module div_iter_core (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      op_req,
  output logic                      op_ack,
  input  div_msg_pkg::div_op_msg_t  op_msg,
  output logic                      raw_req,
  input  logic                      raw_ack,
  output div_msg_pkg::div_raw_msg_t raw_msg
);

  import div_ctrl_pkg::*;

  // index of the final CALC cycle
  localparam logic [`DIV_CNT_W-1:0] last_step = (`DIV_CNT_W)'(`DIV_STEPS - 1);

  div_state_e              state_q;
  div_state_e              state_d;
  div_step_ctl_t           ctl;
  logic [`DIV_CNT_W-1:0]   cnt_q;
  logic                    last;

  // upper DIV_WIDTH+1 bits hold the partial remainder, lower bits the quotient
  logic [2*`DIV_WIDTH:0]   rq_q;
  logic [2*`DIV_WIDTH:0]   rq_init;
  logic [2*`DIV_WIDTH:0]   rq_shift;
  logic [2*`DIV_WIDTH:0]   rq_diff;
  logic [2*`DIV_WIDTH:0]   rq_step;
  logic [2*`DIV_WIDTH:0]   div_aligned;
  logic [`DIV_WIDTH-1:0]   div_q;
  logic                    neg_quo_q;
  logic                    neg_rem_q;

  // -----------------------------------------------------------------------
  // control
  // -----------------------------------------------------------------------

  assign last = (cnt_q == last_step);

  always_comb begin
    // new operands only in IDLE and once the previous ack has fallen
    ctl.load = (state_q == IDLE) && op_req && !op_ack;
    ctl.step = (state_q == CALC);
    ctl.hold = !ctl.load && !ctl.step;

    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (ctl.load) begin
          state_d = CALC;
        end
      end
      CALC: begin
        if (last) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // full four-phase return on the raw link before the next division
        if (!raw_req && !raw_ack) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      op_ack  <= 1'b0;
      raw_req <= 1'b0;
    end else begin
      state_q <= state_d;
      if (ctl.load) begin
        cnt_q <= '0;
      end else if (ctl.step) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // operand ack, raised with the load
      if (ctl.load) begin
        op_ack <= 1'b1;
      end else if (op_ack && !op_req) begin
        op_ack <= 1'b0;
      end
      // result req, raised on the edge into DONE
      if (ctl.step && last) begin
        raw_req <= 1'b1;
      end else if (raw_req && raw_ack) begin
        raw_req <= 1'b0;
      end
    end
  end

  // -----------------------------------------------------------------------
  // datapath
  // -----------------------------------------------------------------------

  assign rq_init     = {{(`DIV_WIDTH + 1){1'b0}}, op_msg.mag_a};
  assign div_aligned = {1'b0, div_q, {`DIV_WIDTH{1'b0}}};
  assign rq_shift    = rq_q << 1;
  assign rq_diff     = rq_shift - div_aligned;

  // keep the difference when it is non-negative and set the quotient bit
  assign rq_step = rq_diff[2*`DIV_WIDTH] ? rq_shift
                                         : {rq_diff[2*`DIV_WIDTH:1], 1'b1};

  always_ff @(posedge clk) begin
    if (!ctl.hold) begin
      rq_q <= ctl.load ? rq_init : rq_step;
    end
    // divisor and sign flags are fixed for the whole division
    if (ctl.load) begin
      div_q     <= op_msg.mag_b;
      neg_quo_q <= op_msg.neg_quo;
      neg_rem_q <= op_msg.neg_rem;
    end
  end

  always_comb begin
    raw_msg.quo     = rq_q[`DIV_WIDTH-1:0];
    raw_msg.rem     = rq_q[2*`DIV_WIDTH-1:`DIV_WIDTH];
    raw_msg.neg_quo = neg_quo_q;
    raw_msg.neg_rem = neg_rem_q;
  end

endmodule

//--- design/div_req_in.sv
// four-phase request receiver with a single operand slot
// a request is not acknowledged while the previous operands wait for the core

`timescale 1ns/1ps

`include "div_defines.svh"

module div_req_in (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      req_req,
  output logic                      req_ack,
  input  div_msg_pkg::div_req_msg_t req_msg,
  output logic                      op_req,
  input  logic                      op_ack,
  output div_msg_pkg::div_op_msg_t  op_msg
);

  import div_msg_pkg::*;

  logic        a_neg;
  logic        b_neg;
  logic        b_zero;
  logic        held;
  logic        accept;
  div_op_msg_t op_next;

  // -----------------------------------------------------------------------
  // sign handling
  // -----------------------------------------------------------------------

  // sign bits only count for signed requests
  assign a_neg  = req_msg.fn & req_msg.a[`DIV_WIDTH-1];
  assign b_neg  = req_msg.fn & req_msg.b[`DIV_WIDTH-1];
  // divide by zero keeps the all-ones quotient unsigned
  assign b_zero = (req_msg.b == '0);

  always_comb begin
    op_next.mag_a   = a_neg ? -req_msg.a : req_msg.a;
    op_next.mag_b   = b_neg ? -req_msg.b : req_msg.b;
    // quotient negative when signs differ
    op_next.neg_quo = (a_neg ^ b_neg) & ~b_zero;
    // remainder follows the dividend
    op_next.neg_rem = a_neg;
  end

  // -----------------------------------------------------------------------
  // handshakes
  // -----------------------------------------------------------------------

  // capture only with an empty slot and the previous ack already low
  assign accept = req_req & ~req_ack & ~held;

  // operand payload, stable until the core acknowledges it
  always_ff @(posedge clk) begin
    if (accept) begin
      op_msg <= op_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_ack <= 1'b0;
      held    <= 1'b0;
      op_req  <= 1'b0;
    end else begin
      // request side, ack drops once req_req is seen low
      if (accept) begin
        req_ack <= 1'b1;
      end else if (req_ack && !req_req) begin
        req_ack <= 1'b0;
      end
      // slot empties when the core has taken the operands
      if (accept) begin
        held <= 1'b1;
      end else if (op_req && op_ack) begin
        held <= 1'b0;
      end
      // op side, wait for the old ack to fall before raising again
      if (op_req && op_ack) begin
        op_req <= 1'b0;
      end else if (held && !op_req && !op_ack) begin
        op_req <= 1'b1;
      end
    end
  end

endmodule

//--- design/div_msg_pkg.sv
// message formats of the divider ports and of the links between its stages
// field order sets the packed layout, so the response has rem in the upper half

`include "div_defines.svh"

package div_msg_pkg;

  // -----------------------------------------------------------------------
  // external messages
  // -----------------------------------------------------------------------

  // fn 0 is unsigned division, fn 1 is signed division
  typedef struct packed {
    logic                  fn;
    logic [`DIV_WIDTH-1:0] a;
    logic [`DIV_WIDTH-1:0] b;
  } div_req_msg_t;

  // one 64-bit word, remainder on top, quotient below
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] rem;
    logic [`DIV_WIDTH-1:0] quo;
  } div_resp_msg_t;

  // -----------------------------------------------------------------------
  // inter-stage messages
  // -----------------------------------------------------------------------

  // operand magnitudes plus the signs the output side has to restore
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] mag_a;
    logic [`DIV_WIDTH-1:0] mag_b;
    logic                  neg_quo;
    logic                  neg_rem;
  } div_op_msg_t;

  // unsigned core result, sign flags passed along untouched
  typedef struct packed {
    logic [`DIV_WIDTH-1:0] quo;
    logic [`DIV_WIDTH-1:0] rem;
    logic                  neg_quo;
    logic                  neg_rem;
  } div_raw_msg_t;

endpackage

//--- design/div_ctrl_pkg.sv
// control types of the iterative core
// the state encoding is 2 bits with one unused code

package div_ctrl_pkg;

  // -----------------------------------------------------------------------
  // core FSM
  // -----------------------------------------------------------------------

  // IDLE waits for operands, CALC iterates, DONE offers the raw result
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } div_state_e;

  // -----------------------------------------------------------------------
  // datapath controls
  // -----------------------------------------------------------------------

  // load  takes new operands into the working registers
  // step  runs one shift-subtract iteration
  // hold  freezes the remainder and quotient register
  typedef struct packed {
    logic load;
    logic step;
    logic hold;
  } div_step_ctl_t;

endpackage

//--- design/div_defines.svh
// width and iteration count of the divider
// DIV_CNT_W has to hold the value DIV_STEPS - 1
// DIV_STEPS stays equal to DIV_WIDTH since the core does one quotient bit per step

`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// -------------------------------------------------------------------------
// operand width
// -------------------------------------------------------------------------

// dividend, divisor, quotient and remainder all share this width
`define DIV_WIDTH 32

// -------------------------------------------------------------------------
// iteration control
// -------------------------------------------------------------------------

// one restoring step per cycle, one step per quotient bit
`define DIV_STEPS `DIV_WIDTH

// step counter width
`define DIV_CNT_W 6

`endif
